//--- hw/axi_types_pkg.sv
// AXI-side types and constants, imported by the bridge RTL that handles AXI channels
`default_nettype none

package axi_types_pkg;

  // --------------------
  // Channel widths
  // --------------------
  typedef logic [31:0] axi_addr_t;   // Byte address
  typedef logic [63:0] axi_data_t;   // One beat on R or W
  typedef logic [7:0]  axi_len_t;    // Beats minus one
  typedef logic [2:0]  axi_size_t;   // Log2 of bytes per beat
  typedef logic [1:0]  axi_resp_t;

  // --------------------
  // Response codes
  // --------------------
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // Eight-byte beat, served as two APB words
  localparam axi_size_t SIZE_DWORD = 3'd3;

endpackage

`default_nettype wire

//--- hw/apb_types_pkg.sv
// APB-side types and slot geometry, imported by the bridge RTL that handles APB words
`default_nettype none

package apb_types_pkg;

  // Peripheral map: eight slots of 4 KB
  localparam int NUM_SLOTS = 8;

  // --------------------
  // Bus widths
  // --------------------
  typedef logic [31:0]          apb_data_t;   // One APB word
  typedef logic [11:0]          apb_addr_t;   // Address inside a slot
  typedef logic [2:0]           slot_idx_t;   // Slot number
  typedef logic [NUM_SLOTS-1:0] psel_t;       // One-hot slot select

  // Address step from the low to the high half of a doubleword
  localparam int WORD_BYTES = 4;

endpackage

`default_nettype wire

//--- hw/apb_word_if.sv
// Carries one APB word request from the decoder to the APB master and its completion back
`default_nettype none

interface apb_word_if;
  import apb_types_pkg::*;

  // Request, held stable from word_valid until word_done
  logic      word_valid;
  logic      word_write;
  slot_idx_t word_slot;
  apb_addr_t word_addr;
  apb_data_t word_wdata;
  logic      word_upper;   // Word belongs to bits 63:32 of the beat

  // Completion, one-cycle pulse with its data
  logic      word_done;
  apb_data_t word_rdata;
  logic      word_err;

  modport issuer (
    output word_valid, word_write, word_slot, word_addr, word_wdata, word_upper,
    input  word_done
  );

  modport executor (
    input  word_valid, word_write, word_slot, word_addr, word_wdata,
    output word_done, word_rdata, word_err
  );

  // Response side only watches completions
  modport observer (
    input word_done, word_rdata, word_err, word_upper, word_write
  );

endinterface

`default_nettype wire

//--- hw/beat_if.sv
// Hands finished beats from the decoder to the response builder with valid/ready
`default_nettype none

interface beat_if;

  logic beat_valid;
  logic beat_write;   // Write beats only pass at the end of the burst
  logic beat_last;
  logic beat_ready;   // Low while R or B waits on the AXI master

  modport source (
    output beat_valid, beat_write, beat_last,
    input  beat_ready
  );

  modport sink (
    input  beat_valid, beat_write, beat_last,
    output beat_ready
  );

endinterface

`default_nettype wire

//--- hw/axi_txn_decoder.sv
// Accepts one AXI read or write and walks its fixed burst as a sequence of APB word requests
`default_nettype none

module axi_txn_decoder (
  input  wire                           ACLK,
  input  wire                           ARESETn,
  // Read address
  input  wire axi_types_pkg::axi_addr_t araddr_i,
  input  wire axi_types_pkg::axi_len_t  arlen_i,
  input  wire axi_types_pkg::axi_size_t arsize_i,
  input  wire                           arvalid_i,
  output logic                          arready_o,
  // Write address
  input  wire axi_types_pkg::axi_addr_t awaddr_i,
  input  wire axi_types_pkg::axi_len_t  awlen_i,
  input  wire axi_types_pkg::axi_size_t awsize_i,
  input  wire                           awvalid_i,
  output logic                          awready_o,
  // Write data
  input  wire axi_types_pkg::axi_data_t wdata_i,
  input  wire                           wvalid_i,
  output logic                          wready_o,
  // Internal links
  apb_word_if.issuer                    word,
  beat_if.source                        beat
);
  import axi_types_pkg::*;
  import apb_types_pkg::*;

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT_WORD, WAIT_BEAT} dec_state_t;

  dec_state_t state_q;
  axi_addr_t  addr_q;
  axi_size_t  size_q;
  axi_len_t   beats_left_q;   // Beats still to run after the current one
  logic       write_q;
  logic       word_idx_q;     // Set while on the high half of a doubleword

  logic       is_dword;
  logic       last_word;
  logic       lane_upper;
  logic       can_issue;
  apb_addr_t  base_addr;

  // --------------------
  // Word plan
  // --------------------
  assign is_dword   = (size_q == SIZE_DWORD);
  assign last_word  = is_dword ? word_idx_q : 1'b1;
  assign lane_upper = is_dword ? word_idx_q : addr_q[$clog2(WORD_BYTES)];
  assign base_addr  = addr_q[$bits(apb_addr_t)-1:0];

  // Write words need the W beat, every word needs room on the response side
  assign can_issue = beat.beat_ready && (!write_q || wvalid_i);

  assign word.word_valid = (state_q == WAIT_WORD) || ((state_q == ISSUE) && can_issue);
  assign word.word_write = write_q;
  assign word.word_slot  = addr_q[$bits(apb_addr_t) +: $bits(slot_idx_t)];
  assign word.word_addr  = word_idx_q ? base_addr + apb_addr_t'(WORD_BYTES) : base_addr;
  assign word.word_upper = lane_upper;
  assign word.word_wdata = lane_upper ? wdata_i[63:32] : wdata_i[31:0];

  // --------------------
  // AXI handshakes
  // --------------------
  assign arready_o = (state_q == IDLE) && arvalid_i;   // Reads win
  assign awready_o = (state_q == IDLE) && !arvalid_i && awvalid_i && wvalid_i;
  assign wready_o  = (state_q == WAIT_WORD) && write_q && last_word && word.word_done;

  assign beat.beat_valid = (state_q == WAIT_BEAT);
  assign beat.beat_write = write_q;
  assign beat.beat_last  = (beats_left_q == '0);

  // Transaction payload
  always_ff @(posedge ACLK) begin
    if (arready_o) begin
      addr_q <= araddr_i;
      size_q <= arsize_i;
    end else if (awready_o) begin
      addr_q <= awaddr_i;
      size_q <= awsize_i;
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state_q      <= IDLE;
      beats_left_q <= '0;
      write_q      <= 1'b0;
      word_idx_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          word_idx_q <= 1'b0;
          if (arready_o) begin
            write_q      <= 1'b0;
            beats_left_q <= arlen_i;
            state_q      <= ISSUE;
          end else if (awready_o) begin
            write_q      <= 1'b1;
            beats_left_q <= awlen_i;
            state_q      <= ISSUE;
          end
        end
        ISSUE: begin
          if (can_issue) state_q <= WAIT_WORD;
        end
        WAIT_WORD: begin
          if (word.word_done) begin
            if (!last_word) begin
              word_idx_q <= 1'b1;   // Go on with the high half
              state_q    <= ISSUE;
            end else begin
              word_idx_q <= 1'b0;
              if (write_q && (beats_left_q != '0)) begin
                beats_left_q <= beats_left_q - 1'b1;   // Next W beat, same address
                state_q      <= ISSUE;
              end else begin
                state_q <= WAIT_BEAT;
              end
            end
          end
        end
        WAIT_BEAT: begin
          if (beat.beat_ready) begin
            if (beats_left_q == '0) begin
              state_q <= IDLE;
            end else begin
              beats_left_q <= beats_left_q - 1'b1;
              state_q      <= ISSUE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/apb_master.sv
// Runs the APB setup and access phases for one word request and picks the addressed slot
`default_nettype none

module apb_master (
  input  wire                                                 ACLK,
  input  wire                                                 ARESETn,
  apb_word_if.executor                                        word,
  // APB
  output apb_types_pkg::psel_t                                psel_o,
  output logic                                                penable_o,
  output logic                                                pwrite_o,
  output apb_types_pkg::apb_addr_t                            paddr_o,
  output apb_types_pkg::apb_data_t                            pwdata_o,
  input  wire apb_types_pkg::apb_data_t [apb_types_pkg::NUM_SLOTS-1:0] prdata_i,
  input  wire apb_types_pkg::psel_t                           pready_i,
  input  wire apb_types_pkg::psel_t                           pslverr_i
);
  import apb_types_pkg::*;

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_t;

  apb_state_t state_q;
  psel_t      slot_sel;
  logic       sel_ready;
  logic       done_q;
  apb_data_t  rdata_q;
  logic       err_q;

  // Slot decode
  assign slot_sel  = psel_t'(1) << word.word_slot;
  assign sel_ready = pready_i[word.word_slot];

  assign psel_o    = (state_q == IDLE) ? '0 : slot_sel;
  assign penable_o = (state_q == ACCESS);
  assign pwrite_o  = word.word_write;
  assign paddr_o   = word.word_addr;   // Request is stable until done
  assign pwdata_o  = word.word_wdata;

  assign word.word_done  = done_q;
  assign word.word_rdata = rdata_q;
  assign word.word_err   = err_q;

  // Completion data, valid with the done pulse
  always_ff @(posedge ACLK) begin
    if ((state_q == ACCESS) && sel_ready) begin
      rdata_q <= prdata_i[word.word_slot];
      err_q   <= pslverr_i[word.word_slot];
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        // The finished word is still valid while done pulses
        IDLE:    if (word.word_valid && !done_q) state_q <= SETUP;
        SETUP:   state_q <= ACCESS;
        ACCESS: begin
          if (sel_ready) begin
            done_q  <= 1'b1;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/axi_resp_builder.sv
// Builds R beats from completed APB words, collects errors and drives the R and B channels
`default_nettype none

module axi_resp_builder (
  input  wire                           ACLK,
  input  wire                           ARESETn,
  apb_word_if.observer                  word,
  beat_if.sink                          beat,
  // Read data
  output axi_types_pkg::axi_data_t      rdata_o,
  output axi_types_pkg::axi_resp_t      rresp_o,
  output logic                          rlast_o,
  output logic                          rvalid_o,
  input  wire                           rready_i,
  // Write response
  output axi_types_pkg::axi_resp_t      bresp_o,
  output logic                          bvalid_o,
  input  wire                           bready_i
);
  import axi_types_pkg::*;

  axi_data_t rdata_q;    // Beat under assembly, then on R
  logic      rerr_q;     // Any word of this R beat failed
  logic      werr_q;     // Any word of this write burst failed
  logic      rlast_q;
  logic      rvalid_q;
  logic      bvalid_q;

  logic      beat_fire;
  logic      r_hs;
  logic      b_hs;

  assign beat.beat_ready = !rvalid_q && !bvalid_q;   // Back-pressure to the decoder
  assign beat_fire       = beat.beat_valid && beat.beat_ready;
  assign r_hs            = rvalid_q && rready_i;
  assign b_hs            = bvalid_q && bready_i;

  assign rdata_o  = rdata_q;
  assign rresp_o  = rerr_q ? RESP_SLVERR : RESP_OKAY;
  assign rlast_o  = rlast_q;
  assign rvalid_o = rvalid_q;
  assign bresp_o  = werr_q ? RESP_SLVERR : RESP_OKAY;
  assign bvalid_o = bvalid_q;

  // --------------------
  // Read side
  // --------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      rdata_q  <= '0;
      rerr_q   <= 1'b0;
      rlast_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else if (r_hs) begin
      rdata_q  <= '0;   // Next beat starts empty
      rerr_q   <= 1'b0;
      rlast_q  <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (word.word_done && !word.word_write) begin
        if (word.word_upper) rdata_q[63:32] <= word.word_rdata;
        else                 rdata_q[31:0]  <= word.word_rdata;
        rerr_q <= rerr_q | word.word_err;
      end
      if (beat_fire && !beat.beat_write) begin
        rvalid_q <= 1'b1;
        rlast_q  <= beat.beat_last;
      end
    end
  end

  // --------------------
  // Write side
  // --------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      werr_q   <= 1'b0;
      bvalid_q <= 1'b0;
    end else if (b_hs) begin
      werr_q   <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (word.word_done && word.word_write) werr_q <= werr_q | word.word_err;
      if (beat_fire && beat.beat_write)      bvalid_q <= 1'b1;   // Last beat only
    end
  end

endmodule

`default_nettype wire

//--- hw/axi2apb_bridge.sv
// AXI4-to-APB bridge top; connect a 64-bit AXI master and eight 4 KB APB slots here
`default_nettype none

module axi2apb_bridge (
  input  wire                           ACLK,
  input  wire                           ARESETn,
  // AXI read address
  input  wire axi_types_pkg::axi_addr_t araddr_i,
  input  wire axi_types_pkg::axi_len_t  arlen_i,
  input  wire axi_types_pkg::axi_size_t arsize_i,
  input  wire                           arvalid_i,
  output logic                          arready_o,
  // AXI write address
  input  wire axi_types_pkg::axi_addr_t awaddr_i,
  input  wire axi_types_pkg::axi_len_t  awlen_i,
  input  wire axi_types_pkg::axi_size_t awsize_i,
  input  wire                           awvalid_i,
  output logic                          awready_o,
  // AXI write data
  input  wire axi_types_pkg::axi_data_t wdata_i,
  input  wire                           wvalid_i,
  output logic                          wready_o,
  // AXI read data
  output axi_types_pkg::axi_data_t      rdata_o,
  output axi_types_pkg::axi_resp_t      rresp_o,
  output logic                          rlast_o,
  output logic                          rvalid_o,
  input  wire                           rready_i,
  // AXI write response
  output axi_types_pkg::axi_resp_t      bresp_o,
  output logic                          bvalid_o,
  input  wire                           bready_i,
  // APB
  output apb_types_pkg::psel_t          psel_o,
  output logic                          penable_o,
  output logic                          pwrite_o,
  output apb_types_pkg::apb_addr_t      paddr_o,
  output apb_types_pkg::apb_data_t      pwdata_o,
  input  wire apb_types_pkg::apb_data_t [apb_types_pkg::NUM_SLOTS-1:0] prdata_i,
  input  wire apb_types_pkg::psel_t     pready_i,
  input  wire apb_types_pkg::psel_t     pslverr_i
);

  apb_word_if word_link ();
  beat_if     beat_link ();

  // Decode and sequence
  axi_txn_decoder u_decoder (
    .ACLK, .ARESETn,
    .araddr_i, .arlen_i, .arsize_i, .arvalid_i, .arready_o,
    .awaddr_i, .awlen_i, .awsize_i, .awvalid_i, .awready_o,
    .wdata_i, .wvalid_i, .wready_o,
    .word (word_link.issuer),
    .beat (beat_link.source)
  );

  // Execute on APB
  apb_master u_apb_master (
    .ACLK, .ARESETn,
    .word (word_link.executor),
    .psel_o, .penable_o, .pwrite_o, .paddr_o, .pwdata_o,
    .prdata_i, .pready_i, .pslverr_i
  );

  // Return R and B
  axi_resp_builder u_resp_builder (
    .ACLK, .ARESETn,
    .word (word_link.observer),
    .beat (beat_link.sink),
    .rdata_o, .rresp_o, .rlast_o, .rvalid_o, .rready_i,
    .bresp_o, .bvalid_o, .bready_i
  );

endmodule

`default_nettype wire

//--- verification/axi2apb_assertions.sv
// Protocol assertions on the bridge top, attached to every axi2apb_bridge instance by bind
`default_nettype none

module axi2apb_assertions (
  input wire                           ACLK,
  input wire                           ARESETn,
  input wire apb_types_pkg::psel_t     psel_o,
  input wire                           penable_o,
  input wire                           pwrite_o,
  input wire apb_types_pkg::apb_addr_t paddr_o,
  input wire axi_types_pkg::axi_data_t rdata_o,
  input wire axi_types_pkg::axi_resp_t rresp_o,
  input wire                           rlast_o,
  input wire                           rvalid_o,
  input wire                           rready_i,
  input wire axi_types_pkg::axi_resp_t bresp_o,
  input wire                           bvalid_o,
  input wire                           bready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // --------------------
  // APB
  // --------------------
  a_psel_onehot: assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(psel_o))
    else $error("PSEL has more than one bit set");

  a_access_after_setup: assert property (@(posedge ACLK) disable iff (!ARESETn)
    penable_o |-> (psel_o != '0) && $stable(psel_o) && $stable(paddr_o) && $stable(pwrite_o))
    else $error("access phase without a matching setup phase");

  // --------------------
  // AXI responses
  // --------------------
  a_r_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o)
                              && $stable(rlast_o))
    else $error("R channel changed before its handshake");

  a_b_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else $error("B channel changed before its handshake");

  a_rlast_in_read: assert property (@(posedge ACLK) disable iff (!ARESETn) rlast_o |-> rvalid_o)
    else $error("RLAST high outside a read beat");

endmodule

bind axi2apb_bridge axi2apb_assertions u_assertions (
  .ACLK, .ARESETn, .psel_o, .penable_o, .pwrite_o, .paddr_o,
  .rdata_o, .rresp_o, .rlast_o, .rvalid_o, .rready_i,
  .bresp_o, .bvalid_o, .bready_i
);

`default_nettype wire

//--- verification/tb_axi2apb.sv
// Testbench for the AXI4-to-APB bridge; drives AXI transactions and models eight APB slots
`default_nettype none

module tb_axi2apb;
  timeunit 1ns;
  timeprecision 1ps;

  import axi_types_pkg::*;
  import apb_types_pkg::*;

  logic ACLK;
  logic ARESETn;
  axi_addr_t araddr, awaddr;
  axi_len_t  arlen, awlen;
  axi_size_t arsize, awsize;
  logic      arvalid, awvalid, wvalid, rready, bready;
  axi_data_t wdata;
  logic      arready_o, awready_o, wready_o, rlast_o, rvalid_o, bvalid_o;
  axi_data_t rdata_o;
  axi_resp_t rresp_o, bresp_o;
  psel_t     psel_o, pready, pslverr;
  logic      penable_o, pwrite_o;
  apb_addr_t paddr_o;
  apb_data_t pwdata_o;
  apb_data_t [NUM_SLOTS-1:0] prdata;

  apb_data_t slot_mem [NUM_SLOTS][16];   // APB slot contents
  apb_data_t exp_mem  [NUM_SLOTS][16];   // What the AXI side expects
  axi_data_t wbuf [256];                 // W beats of the next write
  int        seed;
  int        bp_seed;
  int        wait_left;
  slot_idx_t exp_slot;

  axi2apb_bridge dut (
    .ACLK, .ARESETn,
    .araddr_i(araddr), .arlen_i(arlen), .arsize_i(arsize), .arvalid_i(arvalid),
    .arready_o,
    .awaddr_i(awaddr), .awlen_i(awlen), .awsize_i(awsize), .awvalid_i(awvalid),
    .awready_o,
    .wdata_i(wdata), .wvalid_i(wvalid), .wready_o,
    .rdata_o, .rresp_o, .rlast_o, .rvalid_o, .rready_i(rready),
    .bresp_o, .bvalid_o, .bready_i(bready),
    .psel_o, .penable_o, .pwrite_o, .paddr_o, .pwdata_o,
    .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr)
  );

  initial begin
    ACLK = 1'b0;
    forever #5 ACLK = ~ACLK;
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0d ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "data check failed");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: no %s from the bridge at %0d ns", what, $time);
    $display("SIMULATION FAILED");
    $fatal(1, "wait timed out");
  endtask

  function automatic axi_resp_t expected_resp(input axi_addr_t addr);
    return (addr[14:12] == 3'd7) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  // Doublewords fill two words, narrow accesses one word in the lane of bit 2
  task automatic store_expected(input axi_addr_t addr, input axi_size_t size,
                                input axi_data_t data);
    if (size == SIZE_DWORD) begin
      exp_mem[addr[14:12]][addr[5:2]]     = data[31:0];
      exp_mem[addr[14:12]][addr[5:2] + 1] = data[63:32];
    end else begin
      exp_mem[addr[14:12]][addr[5:2]] = addr[2] ? data[63:32] : data[31:0];
    end
  endtask

  function automatic axi_data_t expected_read(input axi_addr_t addr, input axi_size_t size);
    apb_data_t w;
    w = exp_mem[addr[14:12]][addr[5:2]];
    if (size == SIZE_DWORD) return {exp_mem[addr[14:12]][addr[5:2] + 1], w};
    return addr[2] ? {w, 32'h0} : {32'h0, w};
  endfunction

  // --------------------
  // APB slot model
  // --------------------
  always @(negedge ACLK) begin
    int s;
    pready  = '0;
    pslverr = '0;
    s = 0;
    for (int i = 0; i < NUM_SLOTS; i++) if (psel_o[i]) s = i;
    if (psel_o != '0) begin
      if (psel_o != (psel_t'(1) << exp_slot))
        report_mismatch($sformatf("PSEL %b for slot %0d", psel_o, exp_slot));
      if (!penable_o) begin
        wait_left = $random(seed) & 3;   // Wait states of this access
      end else if (wait_left == 0) begin
        pready[s]  = 1'b1;
        pslverr[s] = (s == 7);
        if (pwrite_o) slot_mem[s][paddr_o[5:2]] = pwdata_o;
        else          prdata[s] = slot_mem[s][paddr_o[5:2]];
      end else begin
        wait_left--;
      end
    end
  end

  task automatic axi_write(input axi_addr_t addr, input int len, input axi_size_t size);
    int   beat;
    int   cycles;
    logic aw_hs, w_hs, b_hs, done;
    axi_resp_t resp;
    beat = 0;
    cycles = 0;
    done = 1'b0;
    exp_slot = addr[14:12];
    @(negedge ACLK);
    awaddr = addr;
    awlen = axi_len_t'(len);
    awsize = size;
    awvalid = 1'b1;
    wvalid = 1'b1;
    wdata = wbuf[0];
    while (!done) begin
      #1;   // Settled values seen by the next rising edge
      aw_hs = awvalid && awready_o;
      w_hs = wvalid && wready_o;
      b_hs = bvalid_o && bready;
      resp = bresp_o;
      @(negedge ACLK);
      if (aw_hs) awvalid = 1'b0;
      if (w_hs) begin
        store_expected(addr, size, wbuf[beat]);
        beat++;
        if (beat > len) wvalid = 1'b0;
        else            wdata = wbuf[beat];
      end
      if (b_hs) begin
        done = 1'b1;
        if (resp != expected_resp(addr))
          report_mismatch($sformatf("BRESP %0d at %h", resp, addr));
      end
      bready = ($random(bp_seed) % 3) == 0;   // Random back-pressure
      cycles++;
      if (cycles > 4000) report_timeout("write response");
    end
  endtask

  task automatic axi_read(input axi_addr_t addr, input int len, input axi_size_t size);
    int   beat;
    int   cycles;
    logic ar_hs, r_hs;
    axi_data_t exp_data;
    beat = 0;
    cycles = 0;
    exp_slot = addr[14:12];
    exp_data = expected_read(addr, size);
    @(negedge ACLK);
    araddr = addr;
    arlen = axi_len_t'(len);
    arsize = size;
    arvalid = 1'b1;
    while (beat <= len) begin
      #1;
      ar_hs = arvalid && arready_o;
      r_hs = rvalid_o && rready;
      if (r_hs) begin
        if (rdata_o != exp_data)
          report_mismatch($sformatf("RDATA %h, expected %h at %h", rdata_o, exp_data, addr));
        if (rresp_o != expected_resp(addr))
          report_mismatch($sformatf("RRESP %0d at %h", rresp_o, addr));
        if (rlast_o != (beat == len))
          report_mismatch($sformatf("RLAST %b on beat %0d", rlast_o, beat));
        beat++;
      end
      @(negedge ACLK);
      if (ar_hs) arvalid = 1'b0;
      rready = ($random(bp_seed) % 3) == 0;
      cycles++;
      if (cycles > 4000) report_timeout("read data");
    end
  endtask

  initial begin
    seed = 32'hd8616213;
    bp_seed = seed;
    wait_left = 0;
    exp_slot = '0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      for (int w = 0; w < 16; w++) begin
        slot_mem[s][w] = 32'(s * 16 + w) * 32'h9e3779b1;   // Fill depends on slot and word
        exp_mem[s][w]  = slot_mem[s][w];
      end
    end
    {araddr, arlen, arsize, arvalid} = '0;
    {awaddr, awlen, awsize, awvalid} = '0;
    {wdata, wvalid, rready, bready} = '0;
    {prdata, pready, pslverr} = '0;
    ARESETn = 1'b0;
    repeat (2) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;

    // Doubleword, then narrow upper lane
    wbuf[0] = 64'h1122334455667788;
    axi_write(32'h0000_2008, 0, 3'd3);
    axi_read(32'h0000_2008, 0, 3'd3);
    wbuf[0] = 64'hcafef00d_deadbeef;
    axi_write(32'h0000_3014, 0, 3'd2);
    axi_read(32'h0000_3014, 0, 3'd2);
    axi_read(32'h0000_3010, 0, 3'd2);

    // Every ordinary slot, then read all back
    for (int s = 0; s < 7; s++) begin
      wbuf[0] = {32'(s) ^ 32'h5a5a0000, 32'h0f0f0000 | 32'(s)};
      axi_write(axi_addr_t'(s << 12) | 32'h20, 0, 3'd2);
    end
    for (int s = 0; s < 7; s++) axi_read(axi_addr_t'(s << 12) | 32'h20, 0, 3'd3);

    // Fixed bursts
    for (int b = 0; b < 4; b++) wbuf[b] = {32'hb0b0_0000 | 32'(b), 32'h0000_beef ^ 32'(b)};
    axi_write(32'h0000_4010, 3, 3'd3);
    axi_read(32'h0000_4010, 3, 3'd3);

    // Mixed traffic under back-pressure
    for (int i = 0; i < 12; i++) begin
      wbuf[0] = {$random(seed), $random(seed)};
      axi_write(axi_addr_t'((i % 7) << 12) | axi_addr_t'((i % 8) * 8), 0, 3'd3);
      axi_read(axi_addr_t'((i % 7) << 12) | axi_addr_t'((i % 8) * 8), 0, 3'd3);
    end

    // Error slot, then normal access again
    wbuf[0] = 64'h0123456789abcdef;
    axi_write(32'h0000_7000, 0, 3'd3);
    axi_read(32'h0000_7000, 0, 3'd3);
    axi_read(32'h0000_2008, 0, 3'd3);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hw/axi_types_pkg.sv
hw/apb_types_pkg.sv
hw/apb_word_if.sv
hw/beat_if.sv
hw/axi_txn_decoder.sv
hw/apb_master.sv
hw/axi_resp_builder.sv
hw/axi2apb_bridge.sv
verification/axi2apb_assertions.sv
verification/tb_axi2apb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := tb_axi2apb
FILELIST  := compile.f
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
